// File: mulTypesPkg.sv
`default_nettype none

package mulTypesPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int nibbleW  = 4;                 // half of an operand
    localparam int operandW = 8;                 // one full operand word

    typedef logic [nibbleW-1:0]    nibbleT;      // one ROM address half
    typedef logic [operandW-1:0]   operandT;     // unsigned multiplicand or multiplier
    typedef logic [2*operandW-1:0] productT;     // full product, also used for nibble products

endpackage

`default_nettype wire

// File: mulCtrlPkg.sv
`default_nettype none

package mulCtrlPkg;

    // clocks from the edge that samples go to the cycle with done high
    localparam int latencyCycles = 9;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // controller states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // encoded in order, so finish carries the value latencyCycles
    typedef enum logic [$clog2(latencyCycles+1)-1:0] {
        idle,
        loadOperands,
        lowProduct,
        crossA,
        crossB,
        highProduct,
        sumCross,
        alignCross,
        addHigh,
        finish
    } mulStateT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // select codes into the datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [1:0] romSelT;                 // which nibble pair addresses the ROM
    localparam romSelT selLowLow   = 2'd0;
    localparam romSelT selHighLow  = 2'd1;       // high of x with low of y
    localparam romSelT selLowHigh  = 2'd2;       // low of x with high of y
    localparam romSelT selHighHigh = 2'd3;

    typedef logic [1:0] sumSelT;                 // which operands go into the shared adder
    localparam sumSelT sumNone      = 2'd0;
    localparam sumSelT sumCrossPair = 2'd1;
    localparam sumSelT sumAlign     = 2'd2;
    localparam sumSelT sumFinal     = 2'd3;

endpackage

`default_nettype wire

// File: nibbleProductRom.sv
`default_nettype none

module nibbleProductRom (
    input  mulTypesPkg::nibbleT  a,
    input  mulTypesPkg::nibbleT  b,
    output mulTypesPkg::productT product
);
    import mulTypesPkg::*;

    localparam int romDepth = 2 ** operandW;     // one entry per concatenated {a, b}

    typedef productT [romDepth-1:0] romImageT;

    // fills the table once at elaboration, the address is {a, b}
    function automatic romImageT buildImage();
        romImageT image;
        nibbleT   hi;
        nibbleT   lo;
        for (int i = 0; i < romDepth; i++) begin
            hi = nibbleT'(i >> nibbleW);
            lo = nibbleT'(i);
            image[i] = productT'(hi) * productT'(lo);
        end
        return image;
    endfunction

    localparam romImageT romImage = buildImage();

    logic [operandW-1:0] addr;

    assign addr    = {a, b};
    assign product = romImage[addr];             // zero-latency lookup

endmodule

`default_nettype wire

// File: mulController.sv
`default_nettype none

module mulController (
    input  logic                clk,
    input  logic                start,
    input  logic                go,
    output logic                ldOperands,
    output logic                ldLowProd,
    output logic                ldCrossA,
    output logic                ldCrossB,
    output logic                ldHighProd,
    output logic                ldCrossSum,
    output logic                ldPartial,
    output logic                ldResult,
    output mulCtrlPkg::romSelT  romSel,
    output mulCtrlPkg::sumSelT  sumSel,
    output logic                busy,
    output logic                done
);
    import mulCtrlPkg::*;

    mulStateT state;
    mulStateT nextState;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state register and sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge start) begin
        if (start) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (go) begin
                    nextState = loadOperands;        // go is only looked at here
                end
            end
            loadOperands: nextState = lowProduct;
            lowProduct:   nextState = crossA;
            crossA:       nextState = crossB;
            crossB:       nextState = highProduct;
            highProduct:  nextState = sumCross;
            sumCross:     nextState = alignCross;
            alignCross:   nextState = addHigh;
            addHigh:      nextState = finish;
            finish:       nextState = idle;
            default:      nextState = idle;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Moore output decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        ldOperands = 1'b0;
        ldLowProd  = 1'b0;
        ldCrossA   = 1'b0;
        ldCrossB   = 1'b0;
        ldHighProd = 1'b0;
        ldCrossSum = 1'b0;
        ldPartial  = 1'b0;
        ldResult   = 1'b0;
        romSel     = selLowLow;
        sumSel     = sumNone;
        done       = 1'b0;
        case (state)
            loadOperands: begin
                ldOperands = 1'b1;                   // x and y sampled at the end of this cycle
            end
            lowProduct: begin
                romSel    = selLowLow;
                ldLowProd = 1'b1;
            end
            crossA: begin
                romSel   = selHighLow;
                ldCrossA = 1'b1;
            end
            crossB: begin
                romSel   = selLowHigh;
                ldCrossB = 1'b1;
            end
            highProduct: begin
                romSel     = selHighHigh;
                ldHighProd = 1'b1;
            end
            sumCross: begin
                sumSel     = sumCrossPair;
                ldCrossSum = 1'b1;
            end
            alignCross: begin
                sumSel    = sumAlign;
                ldPartial = 1'b1;
            end
            addHigh: begin
                sumSel   = sumFinal;
                ldResult = 1'b1;                     // result lands together with done
            end
            finish: begin
                done = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign busy = (state != idle);

endmodule

`default_nettype wire

// File: mulDatapath.sv
`default_nettype none

module mulDatapath (
    input  logic                  clk,
    input  logic                  start,
    input  mulTypesPkg::operandT  x,
    input  mulTypesPkg::operandT  y,
    input  logic                  ldOperands,
    input  logic                  ldLowProd,
    input  logic                  ldCrossA,
    input  logic                  ldCrossB,
    input  logic                  ldHighProd,
    input  logic                  ldCrossSum,
    input  logic                  ldPartial,
    input  logic                  ldResult,
    input  mulCtrlPkg::romSelT    romSel,
    input  mulCtrlPkg::sumSelT    sumSel,
    output mulTypesPkg::productT  result
);
    import mulTypesPkg::*;
    import mulCtrlPkg::*;

    operandT xReg;
    operandT yReg;
    nibbleT  romA;
    nibbleT  romB;
    productT romProduct;
    productT lowProd;
    productT crossAProd;
    productT crossBProd;
    productT highProd;
    productT crossSum;
    productT partial;
    productT addA;
    productT addB;
    productT sum;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // nibble select and product table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (romSel)
            selHighLow: begin
                romA = xReg[operandW-1:nibbleW];
                romB = yReg[nibbleW-1:0];
            end
            selLowHigh: begin
                romA = xReg[nibbleW-1:0];
                romB = yReg[operandW-1:nibbleW];
            end
            selHighHigh: begin
                romA = xReg[operandW-1:nibbleW];
                romB = yReg[operandW-1:nibbleW];
            end
            default: begin
                romA = xReg[nibbleW-1:0];
                romB = yReg[nibbleW-1:0];
            end
        endcase
    end

    nibbleProductRom romInst (
        .a       (romA),
        .b       (romB),
        .product (romProduct)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shared adder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (sumSel)
            sumCrossPair: begin
                addA = crossAProd;
                addB = crossBProd;
            end
            sumAlign: begin
                addA = crossSum << nibbleW;          // cross terms weigh 16
                addB = lowProd;
            end
            sumFinal: begin
                addA = partial;
                addB = highProd << operandW;         // high term weighs 256
            end
            default: begin
                addA = '0;
                addB = '0;
            end
        endcase
    end

    assign sum = addA + addB;                        // never overflows since the full product fits 16 bits

    always_ff @(posedge clk or posedge start) begin
        if (start) begin
            xReg       <= '0;
            yReg       <= '0;
            lowProd    <= '0;
            crossAProd <= '0;
            crossBProd <= '0;
            highProd   <= '0;
            crossSum   <= '0;
            partial    <= '0;
            result     <= '0;
        end else begin
            if (ldOperands) begin
                xReg <= x;
                yReg <= y;
            end
            if (ldLowProd)  lowProd    <= romProduct;
            if (ldCrossA)   crossAProd <= romProduct;
            if (ldCrossB)   crossBProd <= romProduct;
            if (ldHighProd) highProd   <= romProduct;
            if (ldCrossSum) crossSum   <= sum;
            if (ldPartial)  partial    <= sum;
            if (ldResult)   result     <= sum;   // held until the next run reaches addHigh
        end
    end

endmodule

`default_nettype wire

// File: multiplier8.sv
`default_nettype none

module multiplier8 (
    input  logic                  clk,
    input  logic                  start,
    input  logic                  go,
    input  mulTypesPkg::operandT  x,
    input  mulTypesPkg::operandT  y,
    output mulTypesPkg::productT  result,
    output logic                  busy,
    output logic                  done
);
    import mulCtrlPkg::*;

    logic   ldOperands;
    logic   ldLowProd;
    logic   ldCrossA;
    logic   ldCrossB;
    logic   ldHighProd;
    logic   ldCrossSum;
    logic   ldPartial;
    logic   ldResult;
    romSelT romSel;
    sumSelT sumSel;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control and datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    mulController ctrlInst (
        .clk        (clk),
        .start      (start),
        .go         (go),
        .ldOperands (ldOperands),
        .ldLowProd  (ldLowProd),
        .ldCrossA   (ldCrossA),
        .ldCrossB   (ldCrossB),
        .ldHighProd (ldHighProd),
        .ldCrossSum (ldCrossSum),
        .ldPartial  (ldPartial),
        .ldResult   (ldResult),
        .romSel     (romSel),
        .sumSel     (sumSel),
        .busy       (busy),
        .done       (done)
    );

    mulDatapath dpInst (
        .clk        (clk),
        .start      (start),
        .x          (x),
        .y          (y),
        .ldOperands (ldOperands),
        .ldLowProd  (ldLowProd),
        .ldCrossA   (ldCrossA),
        .ldCrossB   (ldCrossB),
        .ldHighProd (ldHighProd),
        .ldCrossSum (ldCrossSum),
        .ldPartial  (ldPartial),
        .ldResult   (ldResult),
        .romSel     (romSel),
        .sumSel     (sumSel),
        .result     (result)
    );

endmodule

`default_nettype wire

// File: multiplier8_chk.sv
`default_nettype none

module multiplier8_chk (
    input logic                  clk,
    input logic                  start,
    input logic                  go,
    input logic                  busy,
    input logic                  done,
    input mulCtrlPkg::mulStateT  state
);
    timeunit 1ns;
    timeprecision 1ps;
    import mulCtrlPkg::*;

    donePulse: assert property (@(posedge clk) disable iff (start) done |=> !done)
        else $error("done stayed high for a second cycle");

    goAccepted: assert property (@(posedge clk) disable iff (start)
        (state == idle && go) |=> (state == loadOperands))
        else $error("go in idle did not lead to loadOperands");

    busyStarts: assert property (@(posedge clk) disable iff (start) $rose(busy) |-> $past(go))
        else $error("busy rose without go being sampled");   // only an accepted go leaves idle

    busyEnds: assert property (@(posedge clk) disable iff (start) $fell(busy) |-> $past(done))
        else $error("busy fell without a done pulse");

endmodule

bind mulController multiplier8_chk chkInst (
    .clk(clk), .start(start), .go(go),
    .busy(busy), .done(done), .state(state)
);

`default_nettype wire

// File: multiplier8_tb.sv
`default_nettype none

module multiplier8_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mulTypesPkg::*;
    import mulCtrlPkg::*;

    localparam int cornerCount = 6;
    localparam int testCount   = cornerCount + 12;       // twelve LCG pairs follow the corners
    localparam int resetCycles = 8;
    localparam int clkPeriod   = 20;

    logic    clk;
    logic    start;
    logic    go;
    operandT x;
    operandT y;
    productT result;
    logic    busy;
    logic    done;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    operandT cornerX [cornerCount] = '{8'd0, 8'd255, 8'd1, 8'd15, 8'd16, 8'd240};
    operandT cornerY [cornerCount] = '{8'd0, 8'd255, 8'd255, 8'd15, 8'd16, 8'd15};
    operandT xTable  [testCount];
    operandT yTable  [testCount];
    logic [31:0] lcgState;
    int errors;
    int failedTests;

    multiplier8 multiplier8_inst (
        .clk    (clk),
        .start  (start),
        .go     (go),
        .x      (x),
        .y      (y),
        .result (result),
        .busy   (busy),
        .done   (done)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkValue(input string name, input int got, input int expected);
        if (got != expected) begin
            errors++;
            $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #((testCount * (latencyCycles + 4) + resetCycles) * clkPeriod);
        $display("timeout, the multiplier stopped completing operations");
        $display("sim failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int      errBefore;
        int      cycles;
        productT expected;
        productT prevExp;
        start       = 1'b1;
        go          = 1'b0;
        x           = '0;
        y           = '0;
        errors      = 0;
        failedTests = 0;
        prevExp     = '0;
        lcgState    = 32'he866_fe05;
        for (int i = 0; i < testCount; i++) begin
            if (i < cornerCount) begin
                xTable[i] = cornerX[i];
                yTable[i] = cornerY[i];
            end else begin
                lcgState  = lcgNext(lcgState);
                xTable[i] = lcgState[23:16];          // middle bits are better mixed than the low ones
                lcgState  = lcgNext(lcgState);
                yTable[i] = lcgState[23:16];
            end
        end

        repeat (resetCycles) @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        checkValue("busy", int'(busy), 0);
        checkValue("done", int'(done), 0);
        checkValue("result", int'(result), 0);
        $display("reset check, %0d errors", errors);

        for (int i = 0; i < testCount; i++) begin
            errBefore = errors;
            expected  = productT'(int'(xTable[i]) * int'(yTable[i]));
            @(posedge clk);
            go <= 1'b1;
            x  <= xTable[i];
            y  <= yTable[i];
            @(posedge clk);                           // go sampled in idle
            go <= 1'b0;
            cycles = 0;
            while (cycles <= latencyCycles + 2) begin
                @(negedge clk);
                cycles++;
                checkValue("busy", int'(busy), 1);
                if (done) break;
                checkValue("result", int'(result), int'(prevExp));  // last product still held
                @(posedge clk);
                go <= (cycles == 1);                  // a second go while busy must be ignored
                if (cycles == 1) begin
                    x <= ~xTable[i];                  // operands were captured in loadOperands
                    y <= yTable[i] + 8'd1;
                end
            end
            if (cycles > latencyCycles + 2) begin
                errors++;
                $display("test %0d, done did not arrive within %0d cycles of go", i, cycles);
            end else begin
                checkValue("latency", cycles, latencyCycles);
                checkValue("result", int'(result), int'(expected));
                @(negedge clk);
                checkValue("done", int'(done), 0);    // single-cycle pulse
                checkValue("result", int'(result), int'(expected));
            end
            prevExp = expected;
            if (errors == errBefore) begin
                $display("test %0d, %0d x %0d = %0d ok", i, xTable[i], yTable[i], result);
            end else begin
                failedTests++;
                $display("test %0d, %0d x %0d mismatch", i, xTable[i], yTable[i]);
            end
        end

        $display("tests %0d, failed %0d, errors %0d", testCount, failedTests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: multiplier8.f
mulTypesPkg.sv
mulCtrlPkg.sv
nibbleProductRom.sv
mulController.sv
mulDatapath.sv
multiplier8.sv
multiplier8_chk.sv
multiplier8_tb.sv

// File: runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module multiplier8_tb -f multiplier8.f -o multiplier8_sim
./obj_dir/multiplier8_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
if grep -q "sim failed" sim.log; then
    exit 1
fi
grep -q "sim passed" sim.log
